//--- alu.sv
/* integer alu */
`timescale 1ns/100ps

module alu (
  input  rv_pkg::alu_op_e i_op,
  input  logic [31:0]     i_a,
  input  logic [31:0]     i_b,
  input  logic [2:0]      i_funct3,  // branch condition
  output logic [31:0]     o_result,
  output logic            o_branch_taken
);

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;

  assign shamt = i_b[4:0];
  assign lt    = $signed(i_a) < $signed(i_b);
  assign ltu   = i_a < i_b;

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:  o_result = i_a + i_b;
      rv_pkg::ALU_SUB:  o_result = i_a - i_b;
      rv_pkg::ALU_SLL:  o_result = i_a << shamt;
      rv_pkg::ALU_SLT:  o_result = {31'd0, lt};
      rv_pkg::ALU_SLTU: o_result = {31'd0, ltu};
      rv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
      rv_pkg::ALU_SRL:  o_result = i_a >> shamt;
      rv_pkg::ALU_SRA:  o_result = $signed(i_a) >>> shamt;
      rv_pkg::ALU_OR:   o_result = i_a | i_b;
      rv_pkg::ALU_AND:  o_result = i_a & i_b;
      default:          o_result = 32'd0;
    endcase
  end

  always_comb begin
    case (i_funct3)
      3'b000:  o_branch_taken = (i_a == i_b);  // beq
      3'b001:  o_branch_taken = (i_a != i_b);  // bne
      3'b100:  o_branch_taken = lt;
      3'b101:  o_branch_taken = !lt;
      3'b110:  o_branch_taken = ltu;
      3'b111:  o_branch_taken = !ltu;
      default: o_branch_taken = 1'b0;
    endcase
  end

endmodule

//--- core_ctrl.sv
/* core sequencer */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module core_ctrl (
  input  logic             clk_in,
  input  logic             i_reset,
  input  logic             i_pause,
  output logic             o_req_valid,
  output rv_pkg::mem_req_t o_req,
  input  logic             i_req_ready,
  input  logic             i_rsp_valid,
  input  rv_pkg::mem_rsp_t i_rsp,
  output rv_pkg::instr_u   o_instr,
  input  rv_pkg::dec_t     i_dec,
  input  logic [31:0]      i_rdata1,
  input  logic [31:0]      i_rdata2,
  output logic             o_rf_we,
  output logic [4:0]       o_rf_rd,
  output logic [31:0]      o_rf_wdata,
  output logic [31:0]      o_alu_a,
  output logic [31:0]      o_alu_b,
  output rv_pkg::alu_op_e  o_alu_op,
  input  logic [31:0]      i_alu_result,
  input  logic             i_branch_taken
);

  typedef enum logic [2:0] {S_FETCH, S_EXEC, S_MEM, S_WB, S_HALT} state_e;

  state_e         state;
  logic [31:0]    pc;
  logic [31:0]    next_pc_q;
  logic [31:0]    res_q;      // alu result, link or load data
  logic [31:0]    st_data_q;
  logic           waiting;    // request accepted, response pending
  rv_pkg::instr_u instr_q;
  logic [31:0]    load_val;
  logic [31:0]    pc_plus4;
  logic [31:0]    br_target;
  logic           is_stop;
  logic           rsp_done;

  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc + i_dec.imm;
  assign is_stop   = i_dec.is_store && (res_q == (`RV_IO_BASE + `RV_IO_STOP));
  assign rsp_done  = waiting && i_rsp_valid;

  assign o_instr    = instr_q;
  assign o_alu_a    = i_dec.a_zero ? 32'd0 : (i_dec.a_pc ? pc : i_rdata1);
  assign o_alu_b    = i_dec.b_imm ? i_dec.imm : i_rdata2;
  assign o_alu_op   = i_dec.alu_op;
  assign o_rf_we    = (state == S_WB) && i_dec.we;
  assign o_rf_rd    = i_dec.rd;
  assign o_rf_wdata = res_q;

  always_comb begin
    if (state == S_MEM) begin
      o_req.addr  = res_q;
      o_req.wdata = st_data_q;
      o_req.write = i_dec.is_store;
      o_req.size  = i_dec.mem_word;
    end else begin
      o_req.addr  = pc;  // instruction fetch
      o_req.wdata = 32'd0;
      o_req.write = 1'b0;
      o_req.size  = 1'b1;
    end
  end

  always_comb begin
    if (i_dec.mem_word) begin
      load_val = i_rsp.data;
    end else if (i_dec.load_unsigned) begin
      load_val = {24'd0, i_rsp.data[7:0]};
    end else begin
      load_val = {{24{i_rsp.data[7]}}, i_rsp.data[7:0]};
    end
  end

  always_ff @(posedge clk_in) begin
    if (i_reset) begin
      state       <= S_FETCH;
      pc          <= `RV_RESET_PC;
      o_req_valid <= 1'b0;
      waiting     <= 1'b0;
    end else if (!i_pause) begin
      if (o_req_valid && i_req_ready) begin
        o_req_valid <= 1'b0;
        waiting     <= 1'b1;
      end
      case (state)
        S_FETCH: begin
          if (!o_req_valid && !waiting) begin
            o_req_valid <= 1'b1;  // first fetch after reset
          end else if (rsp_done) begin
            waiting <= 1'b0;
            state   <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (i_dec.is_load || i_dec.is_store) begin
            o_req_valid <= 1'b1;
            state       <= S_MEM;
          end else begin
            state <= S_WB;
          end
        end
        S_MEM: begin
          if (rsp_done) begin
            waiting <= 1'b0;
            state   <= is_stop ? S_HALT : S_WB;
          end
        end
        S_WB: begin
          pc          <= next_pc_q;
          o_req_valid <= 1'b1;
          state       <= S_FETCH;
        end
        S_HALT: ;  // stopped for good
        default: state <= S_HALT;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (!i_pause) begin
      if (state == S_FETCH && rsp_done) begin
        instr_q <= i_rsp.data;
      end
      if (state == S_EXEC) begin
        if (i_dec.is_jal) begin
          next_pc_q <= i_alu_result;
        end else if (i_dec.is_jalr) begin
          next_pc_q <= {i_alu_result[31:1], 1'b0};
        end else if (i_dec.is_branch && i_branch_taken) begin
          next_pc_q <= br_target;
        end else begin
          next_pc_q <= pc_plus4;
        end
        res_q     <= (i_dec.is_jal || i_dec.is_jalr) ? pc_plus4 : i_alu_result;
        st_data_q <= i_rdata2;
      end
      if (state == S_MEM && rsp_done && i_dec.is_load) begin
        res_q <= load_val;
      end
    end
  end

endmodule

//--- cpu.sv
/* rv32i cpu top */
`timescale 1ns/100ps

module cpu (
  input  logic        clk_in,
  input  logic        i_reset,
  input  logic        i_rdy_in,          // low pauses the core
  input  logic [7:0]  i_mem_din,
  output logic [7:0]  o_mem_dout,
  output logic [31:0] o_mem_a,
  output logic        o_mem_wr,          // 1 for write
  input  logic        i_io_buffer_full,  // uart buffer full
  output logic [31:0] o_dbgreg_dout
);

  logic             pause;
  logic             req_valid;
  logic             req_ready;
  logic             rsp_valid;
  rv_pkg::mem_req_t req;
  rv_pkg::mem_rsp_t rsp;
  rv_pkg::instr_u   instr;
  rv_pkg::dec_t     dec;
  logic [31:0]      rdata1;
  logic [31:0]      rdata2;
  logic             rf_we;
  logic [4:0]       rf_rd;
  logic [31:0]      rf_wdata;
  logic [31:0]      alu_a;
  logic [31:0]      alu_b;
  rv_pkg::alu_op_e  alu_op;
  logic [31:0]      alu_result;
  logic             branch_taken;

  assign pause = !i_rdy_in;

  mem_port mem_port0 (
    .clk_in      (clk_in),
    .i_reset     (i_reset),
    .i_pause     (pause),
    .i_io_full   (i_io_buffer_full),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_req_ready (req_ready),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp),
    .i_mem_din   (i_mem_din),
    .o_mem_dout  (o_mem_dout),
    .o_mem_a     (o_mem_a),
    .o_mem_wr    (o_mem_wr)
  );

  decoder decoder0 (
    .i_instr (instr),
    .o_dec   (dec)
  );

  alu alu0 (
    .i_op           (alu_op),
    .i_a            (alu_a),
    .i_b            (alu_b),
    .i_funct3       (instr.r.funct3),
    .o_result       (alu_result),
    .o_branch_taken (branch_taken)
  );

  reg_file reg_file0 (
    .clk_in    (clk_in),
    .i_reset   (i_reset),
    .i_pause   (pause),
    .i_we      (rf_we),
    .i_rd      (rf_rd),
    .i_wdata   (rf_wdata),
    .i_rs1     (dec.rs1),
    .i_rs2     (dec.rs2),
    .o_rdata1  (rdata1),
    .o_rdata2  (rdata2),
    .o_dbg_x10 (o_dbgreg_dout)
  );

  core_ctrl core_ctrl0 (
    .clk_in         (clk_in),
    .i_reset        (i_reset),
    .i_pause        (pause),
    .o_req_valid    (req_valid),
    .o_req          (req),
    .i_req_ready    (req_ready),
    .i_rsp_valid    (rsp_valid),
    .i_rsp          (rsp),
    .o_instr        (instr),
    .i_dec          (dec),
    .i_rdata1       (rdata1),
    .i_rdata2       (rdata2),
    .o_rf_we        (rf_we),
    .o_rf_rd        (rf_rd),
    .o_rf_wdata     (rf_wdata),
    .o_alu_a        (alu_a),
    .o_alu_b        (alu_b),
    .o_alu_op       (alu_op),
    .i_alu_result   (alu_result),
    .i_branch_taken (branch_taken)
  );

endmodule

//--- cpu_assert.sv
/* bus and handshake checks */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module cpu_assert (
  input logic             clk_in,
  input logic             i_reset,
  input logic             i_rdy_in,
  input logic             i_io_buffer_full,
  input logic             o_mem_wr,
  input logic [31:0]      o_mem_a,
  input logic             req_valid,
  input logic             req_ready,
  input rv_pkg::mem_req_t req
);

  a_no_wr_paused: assert property (@(posedge clk_in) disable iff (i_reset)
    !i_rdy_in |-> !o_mem_wr)
    else $error("bus write while paused");

  a_uart_held: assert property (@(posedge clk_in) disable iff (i_reset)
    (o_mem_wr && o_mem_a == (`RV_IO_BASE + `RV_IO_UART)) |-> !i_io_buffer_full)
    else $error("uart write while buffer full");

  // request held until the port takes it
  a_req_stable: assert property (@(posedge clk_in) disable iff (i_reset)
    (req_valid && !req_ready) |=> (req_valid && $stable(req)))
    else $error("request changed before ready");

  a_reset_wr: assert property (@(posedge clk_in) i_reset |=> !o_mem_wr)
    else $error("bus write right after reset");

endmodule

bind cpu cpu_assert cpu_assert0 (
  .clk_in           (clk_in),
  .i_reset          (i_reset),
  .i_rdy_in         (i_rdy_in),
  .i_io_buffer_full (i_io_buffer_full),
  .o_mem_wr         (o_mem_wr),
  .o_mem_a          (o_mem_a),
  .req_valid        (req_valid),
  .req_ready        (req_ready),
  .req              (req)
);

//--- decoder.sv
/* instruction decoder */
`timescale 1ns/100ps

module decoder (
  input  rv_pkg::instr_u i_instr,
  output rv_pkg::dec_t   o_dec
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // funct3 to alu op, alt selects sub and sra
  function automatic rv_pkg::alu_op_e alu_map(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    o_dec     = '0;  // unknown opcode stays a no-op
    o_dec.rd  = i_instr.r.rd;
    o_dec.rs1 = i_instr.r.rs1;
    o_dec.rs2 = i_instr.r.rs2;
    case (i_instr.r.opcode)
      OP_LUI: begin
        o_dec.imm    = {i_instr.u.imm31_12, 12'd0};
        o_dec.a_zero = 1'b1;
        o_dec.b_imm  = 1'b1;
        o_dec.we     = 1'b1;
      end
      OP_AUIPC: begin
        o_dec.imm   = {i_instr.u.imm31_12, 12'd0};
        o_dec.a_pc  = 1'b1;
        o_dec.b_imm = 1'b1;
        o_dec.we    = 1'b1;
      end
      OP_JAL: begin
        o_dec.imm    = {{11{i_instr.j.imm20}}, i_instr.j.imm20, i_instr.j.imm19_12,
                        i_instr.j.imm11, i_instr.j.imm10_1, 1'b0};
        o_dec.a_pc   = 1'b1;
        o_dec.b_imm  = 1'b1;
        o_dec.is_jal = 1'b1;
        o_dec.we     = 1'b1;
      end
      OP_JALR: begin
        o_dec.imm     = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
        o_dec.b_imm   = 1'b1;
        o_dec.is_jalr = 1'b1;
        o_dec.we      = 1'b1;
      end
      OP_BRANCH: begin
        o_dec.imm       = {{19{i_instr.b.imm12}}, i_instr.b.imm12, i_instr.b.imm11,
                           i_instr.b.imm10_5, i_instr.b.imm4_1, 1'b0};
        o_dec.is_branch = 1'b1;  // compare rs1 with rs2
      end
      OP_LOAD: begin
        o_dec.imm           = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
        o_dec.b_imm         = 1'b1;
        o_dec.is_load       = 1'b1;
        o_dec.mem_word      = (i_instr.i.funct3 == 3'b010);
        o_dec.load_unsigned = i_instr.i.funct3[2];
        o_dec.we            = 1'b1;
      end
      OP_STORE: begin
        o_dec.imm      = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
        o_dec.b_imm    = 1'b1;
        o_dec.is_store = 1'b1;
        o_dec.mem_word = i_instr.s.funct3[1];
      end
      OP_IMM: begin
        o_dec.imm    = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
        o_dec.b_imm  = 1'b1;
        o_dec.alu_op = alu_map(i_instr.i.funct3,
                               (i_instr.i.funct3 == 3'b101) && i_instr.r.funct7[5]);
        o_dec.we     = 1'b1;
      end
      OP_REG: begin
        o_dec.alu_op = alu_map(i_instr.r.funct3, i_instr.r.funct7[5]);
        o_dec.we     = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- files.f
+incdir+.
rv_pkg.sv
mem_port.sv
decoder.sv
alu.sv
reg_file.sv
core_ctrl.sv
cpu.sv
cpu_assert.sv
tb_cpu.sv

//--- mem_port.sv
/* byte-serial memory port */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module mem_port (
  input  logic             clk_in,
  input  logic             i_reset,
  input  logic             i_pause,
  input  logic             i_io_full,
  input  logic             i_req_valid,
  input  rv_pkg::mem_req_t i_req,
  output logic             o_req_ready,
  output logic             o_rsp_valid,
  output rv_pkg::mem_rsp_t o_rsp,
  input  logic [7:0]       i_mem_din,
  output logic [7:0]       o_mem_dout,
  output logic [31:0]      o_mem_a,
  output logic             o_mem_wr
);

  rv_pkg::mem_req_t req_q;
  logic        busy;       // address cycles in progress
  logic [1:0]  cnt;        // current byte
  logic [1:0]  last_idx;
  logic        rd_pend;    // a read byte returns this cycle
  logic [1:0]  rd_idx;
  logic        rd_last;
  logic [31:0] asm_q;      // read assembly
  logic [31:0] bus_addr;
  logic        is_uart;
  logic        stall;
  logic        step;

  assign last_idx = req_q.size ? 2'd3 : 2'd0;
  assign bus_addr = req_q.addr + {30'd0, cnt};
  assign is_uart  = (req_q.addr == (`RV_IO_BASE + `RV_IO_UART));
  assign stall    = req_q.write && is_uart && i_io_full;  // hold uart byte while full
  assign step     = busy && !i_pause && !stall;

  assign o_req_ready = !busy && !rd_pend && !o_rsp_valid;
  // only bits RV_MEM_AW:0 are decoded outside
  assign o_mem_a    = busy ? {{(31 - `RV_MEM_AW){1'b0}}, bus_addr[`RV_MEM_AW:0]} : 32'd0;
  assign o_mem_dout = busy ? req_q.wdata[{cnt, 3'b000} +: 8] : 8'd0;
  assign o_mem_wr   = step && req_q.write;
  assign o_rsp.data = asm_q;

  always_ff @(posedge clk_in) begin
    if (i_reset) begin
      busy        <= 1'b0;
      cnt         <= 2'd0;
      rd_pend     <= 1'b0;
      rd_idx      <= 2'd0;
      rd_last     <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else if (!i_pause) begin
      rd_pend <= busy && !req_q.write;
      rd_idx  <= cnt;
      rd_last <= busy && !req_q.write && (cnt == last_idx);
      // load answers after its last byte, store after its last write
      o_rsp_valid <= (rd_pend && rd_last) ||
                     (step && req_q.write && (cnt == last_idx));
      if (step) begin
        if (cnt == last_idx) begin
          busy <= 1'b0;
        end else begin
          cnt <= cnt + 2'd1;
        end
      end else if (i_req_valid && o_req_ready) begin
        busy <= 1'b1;
        cnt  <= 2'd0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (!i_pause) begin
      if (i_req_valid && o_req_ready) begin
        req_q <= i_req;
      end
      if (rd_pend) begin
        asm_q[{rd_idx, 3'b000} +: 8] <= i_mem_din;  // little-endian
      end
    end
  end

endmodule

//--- reg_file.sv
/* register file */
`timescale 1ns/100ps

module reg_file (
  input  logic        clk_in,
  input  logic        i_reset,
  input  logic        i_pause,
  input  logic        i_we,
  input  logic [4:0]  i_rd,
  input  logic [31:0] i_wdata,
  input  logic [4:0]  i_rs1,
  input  logic [4:0]  i_rs2,
  output logic [31:0] o_rdata1,
  output logic [31:0] o_rdata2,
  output logic [31:0] o_dbg_x10
);

  logic [31:0] regs [32];  // entry 0 is never written

  assign o_rdata1  = regs[i_rs1];
  assign o_rdata2  = regs[i_rs2];
  assign o_dbg_x10 = regs[10];  // a0

  always_ff @(posedge clk_in) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (!i_pause && i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f files.f -o sim_tb_cpu
./obj_dir/sim_tb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1

//--- rv_cfg.svh
/* core configuration */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// valid memory address bits, 128 KB
`define RV_MEM_AW 17

// i/o region, address bits 17:16 both set
`define RV_IO_BASE 32'h0003_0000

// offsets inside the i/o region
`define RV_IO_UART 32'h0000_0000  // byte out to uart
`define RV_IO_STOP 32'h0000_0004  // program stop

`endif

//--- rv_pkg.sv
/* rv32i core types */
package rv_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // instruction word layouts
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        a_pc;           // operand a is the pc
    logic        a_zero;         // operand a is zero (lui)
    logic        b_imm;          // operand b is the immediate
    logic        is_load;
    logic        is_store;
    logic        mem_word;       // word access, else byte
    logic        load_unsigned;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        we;
  } dec_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
    logic        size;  // 1 word, 0 byte
  } mem_req_t;

  typedef struct packed {
    logic [31:0] data;
  } mem_rsp_t;

endpackage

//--- tb_cpu.sv
/* rv32i cpu testbench */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module tb_cpu;

  logic        clk_in;
  logic        i_reset;
  logic        i_rdy_in;
  logic [7:0]  i_mem_din;
  logic [7:0]  o_mem_dout;
  logic [31:0] o_mem_a;
  logic        o_mem_wr;
  logic        i_io_buffer_full;
  logic [31:0] o_dbgreg_dout;

  logic [7:0]  mem [0:131071];      // bus side memory
  logic [7:0]  ref_mem [0:131071];  // model memory
  logic [31:0] xr [32];             // model registers
  logic [7:0]  uart_q[$];
  logic [7:0]  ref_uart_q[$];
  logic [31:0] gen_seed = 32'h14e7_07b6;
  logic [31:0] drv_seed = 32'h14e7_07b6 ^ 32'h5a5a_a5a5;
  logic [31:0] rd_addr = 32'd0;
  int          wr_count;
  int          ref_wr_count;
  int          errors;
  int          checks;
  int          failed_tests;
  bit          stop_seen;
  bit          pause_en;
  bit          full_en;

  cpu dut0 (.*);

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  function automatic logic [31:0] lcg(inout logic [31:0] s);
    s = s * 32'd1664525 + 32'd1013904223;
    return s;
  endfunction

  function automatic int rnd(int n);
    logic [31:0] v;
    v = lcg(gen_seed);
    return int'(v[31:8] % n);
  endfunction

  function automatic logic [7:0] bus_byte(logic [31:0] a);
    if (a[17:16] == 2'b11) return 8'd0;
    return mem[a[16:0]];
  endfunction

  // inputs change shortly after the rising edge
  always @(posedge clk_in) begin
    logic [31:0] v;
    #2;
    v = lcg(drv_seed);
    i_rdy_in = !(pause_en && (v[31:8] % 3 == 0));
    i_io_buffer_full = full_en && v[5];
    i_mem_din = bus_byte(rd_addr);
  end

  // bus outputs are stable at the falling edge
  always @(negedge clk_in) begin
    if (i_rdy_in) begin
      rd_addr = o_mem_a;
      if (o_mem_wr) begin
        wr_count++;
        if (o_mem_a == `RV_IO_BASE + `RV_IO_UART) uart_q.push_back(o_mem_dout);
        else if (o_mem_a == `RV_IO_BASE + `RV_IO_STOP) stop_seen = 1'b1;
        else if (o_mem_a[17:16] != 2'b11) mem[o_mem_a[16:0]] = o_mem_dout;
      end
    end
  end

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic void put_word(int a, logic [31:0] w);
    for (int k = 0; k < 4; k++) begin
      mem[a + k] = w[8*k +: 8];
      ref_mem[a + k] = w[8*k +: 8];
    end
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, int f3, int rd, int op);
    return {imm, 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, int f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
  endfunction

  // random body, then register dump, uart bytes and the stop write
  function automatic void build_program(logic [2:0] mode, int n);
    int idx;
    int k;
    int f3;
    int rx;
    int hop;
    int reach;  // furthest jump target so far, in words
    logic [11:0] imm;
    int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    for (int a = 0; a < 131072; a++) begin
      mem[a] = 8'd0;
      ref_mem[a] = 8'd0;
    end
    for (int a = 'h600; a < 'h700; a++) begin
      mem[a] = 8'(rnd(256));  // scratch area
      ref_mem[a] = mem[a];
    end
    idx = 0;
    reach = 0;
    while (idx < n) begin
      k = rnd(3);
      if (!mode[k]) k = 0;
      f3 = rnd(8);
      if (k == 0) begin
        case (rnd(4))
          0: put_word(idx * 4, {(f3 == 0 || f3 == 5) && rnd(2) == 1 ? 7'h20 : 7'h00,
                                5'(rnd(32)), 5'(rnd(32)), 3'(f3), 5'(1 + rnd(31)), 7'h33});
          1: begin
            imm = 12'(rnd(4096));
            if (f3 == 1) imm = {7'h00, imm[4:0]};
            if (f3 == 5) imm = {imm[10] ? 7'h20 : 7'h00, imm[4:0]};
            put_word(idx * 4, enc_i(imm, rnd(32), f3, 1 + rnd(31), 'h13));
          end
          2: put_word(idx * 4, {20'(lcg(gen_seed)), 5'(1 + rnd(31)), 7'h37});
          default: put_word(idx * 4, {20'(lcg(gen_seed)), 5'(1 + rnd(31)), 7'h17});
        endcase
      end else if (k == 1) begin
        if (rnd(2) == 0) begin
          f3 = rnd(3) == 0 ? 2 : (rnd(2) == 0 ? 0 : 4);
          imm = 12'('h600 + (f3 == 2 ? rnd(64) * 4 : rnd(256)));
          put_word(idx * 4, enc_i(imm, 0, f3, 1 + rnd(31), 'h03));
        end else begin
          f3 = rnd(2) * 2;
          imm = 12'('h600 + (f3 == 2 ? rnd(64) * 4 : rnd(256)));
          put_word(idx * 4, enc_s(imm, rnd(32), 0, f3));
        end
      end else begin
        rx = rnd(3);
        // a jalr must not be entered without its auipc
        if (rx == 2 && (n - idx < 2 || reach > idx)) rx = 0;
        if (rx == 0) begin
          hop = 1 + rnd(n - idx < 4 ? n - idx : 4);
          put_word(idx * 4, enc_b(13'(4 * hop), rnd(4), rnd(4), br_f3[rnd(6)]));
        end else if (rx == 1) begin
          hop = 1 + rnd(n - idx < 4 ? n - idx : 4);
          put_word(idx * 4, enc_j(21'(4 * hop), rnd(32)));
        end else begin
          rx = 1 + rnd(31);  // auipc base, then jalr forward
          put_word(idx * 4, {20'd0, 5'(rx), 7'h17});
          idx++;
          hop = 1 + rnd(n - idx < 4 ? n - idx : 4);
          put_word(idx * 4, enc_i(12'(4 + 4 * hop), rx, 0, rnd(32), 'h67));
        end
        if (reach < idx + hop) reach = idx + hop;
      end
      idx++;
    end
    for (int r = 1; r < 32; r++) put_word((n + r - 1) * 4, enc_s(12'('h700 + 4 * r), r, 0, 2));
    idx = n + 31;
    put_word(idx * 4, {20'h00030, 5'd1, 7'h37});  // x1 = i/o base
    for (int u = 0; u < 4; u++) begin
      put_word((idx + 1 + 2 * u) * 4, enc_i(12'(1 + rnd(255)), 0, 0, 2, 'h13));
      put_word((idx + 2 + 2 * u) * 4, enc_s(12'(`RV_IO_UART), 2, 1, 0));
    end
    put_word((idx + 9) * 4, enc_s(12'(`RV_IO_STOP), 0, 1, 2));
  endfunction

  function automatic logic [31:0] alu_calc(int f3, bit alt, logic [31:0] a, logic [31:0] b);
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return {31'd0, $signed(a) < $signed(b)};
      3: return {31'd0, a < b};
      4: return a ^ b;
      5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // instruction-set model
  function automatic void iss_run();
    logic [31:0] pc;
    logic [31:0] nxt;
    logic [31:0] w;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] a;
    logic [31:0] ii;
    logic [31:0] bi;
    logic [31:0] ji;
    bit          tk;
    bit          done;
    int          rd;
    int          f3;
    pc = `RV_RESET_PC;
    done = 1'b0;
    ref_wr_count = 0;
    foreach (xr[r]) xr[r] = 32'd0;
    for (int s = 0; s < 20000 && !done; s++) begin
      w = {ref_mem[pc[16:0] + 3], ref_mem[pc[16:0] + 2],
           ref_mem[pc[16:0] + 1], ref_mem[pc[16:0]]};
      v1 = xr[w[19:15]];
      v2 = xr[w[24:20]];
      rd = int'(w[11:7]);
      f3 = int'(w[14:12]);
      ii = {{20{w[31]}}, w[31:20]};
      bi = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      ji = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      nxt = pc + 4;
      case (w[6:0])
        7'h37: xr[rd] = {w[31:12], 12'd0};
        7'h17: xr[rd] = pc + {w[31:12], 12'd0};
        7'h6f: begin
          xr[rd] = pc + 4;
          nxt = pc + ji;
        end
        7'h67: begin
          nxt = (v1 + ii) & ~32'd1;
          xr[rd] = pc + 4;
        end
        7'h63: begin
          case (f3)
            0: tk = v1 == v2;
            1: tk = v1 != v2;
            4: tk = $signed(v1) < $signed(v2);
            5: tk = $signed(v1) >= $signed(v2);
            6: tk = v1 < v2;
            default: tk = v1 >= v2;
          endcase
          if (tk) nxt = pc + bi;
        end
        7'h03: begin
          a = v1 + ii;
          if (f3 == 2) xr[rd] = {ref_mem[a[16:0] + 3], ref_mem[a[16:0] + 2],
                                 ref_mem[a[16:0] + 1], ref_mem[a[16:0]]};
          else if (f3 == 4) xr[rd] = {24'd0, ref_mem[a[16:0]]};
          else xr[rd] = {{24{ref_mem[a[16:0]][7]}}, ref_mem[a[16:0]]};
        end
        7'h23: begin
          a = v1 + {{20{w[31]}}, w[31:25], w[11:7]};
          ref_wr_count += (f3 == 2) ? 4 : 1;
          if (a == `RV_IO_BASE + `RV_IO_STOP) done = 1'b1;
          else if (a == `RV_IO_BASE + `RV_IO_UART) ref_uart_q.push_back(v2[7:0]);
          else begin
            for (int k = 0; k < ((f3 == 2) ? 4 : 1); k++) begin
              ref_mem[a[16:0] + k] = v2[8*k +: 8];
            end
          end
        end
        7'h13: xr[rd] = alu_calc(f3, f3 == 5 && w[30], v1, ii);
        7'h33: xr[rd] = alu_calc(f3, w[30], v1, v2);
        default: ;
      endcase
      xr[0] = 32'd0;
      pc = nxt;
    end
  endfunction

  task automatic run_test(int id, string name, logic [2:0] mode, bit p_en, bit f_en);
    int err0;
    int cyc;
    err0 = errors;
    #2 i_reset = 1'b1;
    pause_en = 1'b0;
    full_en = 1'b0;
    build_program(mode, 120);
    uart_q.delete();
    ref_uart_q.delete();
    iss_run();
    wr_count = 0;
    stop_seen = 1'b0;
    repeat (8) @(posedge clk_in);
    #2 i_reset = 1'b0;
    pause_en = p_en;
    full_en = f_en;
    cyc = 0;
    while (!stop_seen && cyc < 100000) begin
      @(posedge clk_in);
      cyc++;
    end
    if (!stop_seen) begin
      $display("test %0d: timed out waiting for the stop write", id);
      errors++;
    end else begin
      repeat (200) @(posedge clk_in);  // quiet window after the stop write
      check_val("bus write count", wr_count, ref_wr_count);
      for (int a = 'h600; a < 'h780; a++) begin
        check_val($sformatf("mem[%h]", a), mem[a], ref_mem[a]);
      end
      check_val("uart byte count", uart_q.size(), ref_uart_q.size());
      foreach (ref_uart_q[k]) begin
        if (k < uart_q.size()) check_val("uart byte", uart_q[k], ref_uart_q[k]);
      end
      check_val("dbgreg_dout", o_dbgreg_dout, xr[10]);
    end
    if (errors != err0) failed_tests++;
    $display("test %0d %s: %s", id, name, (errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    i_reset = 1'b1;
    i_rdy_in = 1'b1;
    i_mem_din = 8'd0;
    i_io_buffer_full = 1'b0;
    errors = 0;
    checks = 0;
    failed_tests = 0;
    run_test(1, "arithmetic", 3'b001, 1'b0, 1'b0);
    run_test(2, "loads and stores", 3'b011, 1'b0, 1'b0);
    run_test(3, "control flow", 3'b101, 1'b0, 1'b0);
    run_test(4, "pause", 3'b111, 1'b1, 1'b0);
    run_test(5, "uart and halt", 3'b111, 1'b0, 1'b1);
    $display("tests 5, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
